// ==== Makefile ====
# Verilator build and run of the data bus testbench

TOP     = tb_soc_bus_top
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f soc_bus_top.f -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

// ==== include/soc_bus_settings.svh ====
/*
  Data bus widths, SRAM geometry, address map of the
  SRAM, ticker and GPIO regions, and register offsets
  within the 256-byte register pages
*/
`ifndef SOC_BUS_SETTINGS_SVH
`define SOC_BUS_SETTINGS_SVH

`define SOC_DATA_W          32
`define SOC_ADDR_W          32
`define SOC_BE_W            4
`define SOC_SRAM_AW         20
`define SOC_SRAM_BANK_BIT   22

`define SOC_SRAM_BASE       32'h0000_0000
`define SOC_SRAM_MASK       32'hff80_0000   // 8 MB, both banks
`define SOC_TICKER_BASE     32'h1fd0_0100
`define SOC_GPIO_BASE       32'h1fd0_0200
`define SOC_REG_PAGE_MASK   32'hffff_ff00

`define SOC_TICK_COUNT      32'h0000_0000
`define SOC_TICK_COMPARE    32'h0000_0004
`define SOC_GPIO_OUT        32'h0000_0000
`define SOC_GPIO_IN         32'h0000_0004

`endif

// ==== logic/data_bus_decode.sv ====
/*
  Data bus address decoder
  region match, request gating to one device,
  read data mux and stall forwarding from the SRAM
*/
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_settings.svh"

module data_bus_decode (
    input  wire  [`SOC_ADDR_W-1:0] bus_addr_i,
    input  wire  [`SOC_DATA_W-1:0] bus_wdata_i,
    input  wire  [`SOC_BE_W-1:0]   bus_byte_en_i,
    input  wire                    bus_read_i,
    input  wire                    bus_write_i,
    output logic [`SOC_DATA_W-1:0] bus_rdata_o,
    output logic                   bus_stall_o,
    dev_bus_if.dec                 sram_bus,
    dev_bus_if.dec                 tick_bus,
    dev_bus_if.dec                 gpio_bus
);

    soc_bus_pkg::dev_sel_e sel;

    always_comb begin
        if ((bus_addr_i & `SOC_SRAM_MASK) == `SOC_SRAM_BASE) begin
            sel = soc_bus_pkg::DEV_SRAM;
        end else if ((bus_addr_i & `SOC_REG_PAGE_MASK) == `SOC_TICKER_BASE) begin
            sel = soc_bus_pkg::DEV_TICKER;
        end else if ((bus_addr_i & `SOC_REG_PAGE_MASK) == `SOC_GPIO_BASE) begin
            sel = soc_bus_pkg::DEV_GPIO;
        end else begin
            sel = soc_bus_pkg::DEV_NONE;
        end
    end

    assign sram_bus.addr    = bus_addr_i & ~`SOC_SRAM_MASK;     // keeps bank bit
    assign sram_bus.wdata   = bus_wdata_i;
    assign sram_bus.byte_en = bus_byte_en_i;
    assign sram_bus.read    = bus_read_i && (sel == soc_bus_pkg::DEV_SRAM);
    assign sram_bus.write   = bus_write_i && (sel == soc_bus_pkg::DEV_SRAM);

    assign tick_bus.addr    = bus_addr_i & ~`SOC_REG_PAGE_MASK;
    assign tick_bus.wdata   = bus_wdata_i;
    assign tick_bus.byte_en = bus_byte_en_i;
    assign tick_bus.read    = bus_read_i && (sel == soc_bus_pkg::DEV_TICKER);
    assign tick_bus.write   = bus_write_i && (sel == soc_bus_pkg::DEV_TICKER);

    assign gpio_bus.addr    = bus_addr_i & ~`SOC_REG_PAGE_MASK;
    assign gpio_bus.wdata   = bus_wdata_i;
    assign gpio_bus.byte_en = bus_byte_en_i;
    assign gpio_bus.read    = bus_read_i && (sel == soc_bus_pkg::DEV_GPIO);
    assign gpio_bus.write   = bus_write_i && (sel == soc_bus_pkg::DEV_GPIO);

    always_comb begin
        case (sel)
            soc_bus_pkg::DEV_SRAM:   bus_rdata_o = sram_bus.rdata;
            soc_bus_pkg::DEV_TICKER: bus_rdata_o = tick_bus.rdata;
            soc_bus_pkg::DEV_GPIO:   bus_rdata_o = gpio_bus.rdata;
            default:                 bus_rdata_o = '0;   // unmapped reads as zero
        endcase
    end

    // register pages never hold the bus
    assign bus_stall_o = (sel == soc_bus_pkg::DEV_SRAM) ? sram_bus.stall : 1'b0;

endmodule

`default_nettype wire

// ==== logic/dev_bus_if.sv ====
/*
  One device access as seen behind the decoder,
  with modports for the decoder, memory and register targets
*/
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_settings.svh"

interface dev_bus_if;

    logic [`SOC_ADDR_W-1:0] addr;       // offset within the region
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_BE_W-1:0]   byte_en;
    logic                   read;
    logic                   write;
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   stall;

    modport dec  (output addr, wdata, byte_en, read, write, input rdata, stall);
    modport mem  (input addr, wdata, byte_en, read, write, output rdata, stall);
    // register targets complete in one cycle, no stall
    modport regs (input addr, wdata, byte_en, read, write, output rdata);

endinterface

`default_nettype wire

// ==== logic/gpio_regs.sv ====
/*
  GPIO register block
  byte-writable output register, synchronized input register
*/
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_settings.svh"

module gpio_regs (
    input  wire                    clk,
    input  wire                    arst_n_i,
    dev_bus_if.regs                bus,
    input  wire  [`SOC_DATA_W-1:0] gpio_in_i,
    output logic [`SOC_DATA_W-1:0] gpio_out_o
);

    logic [`SOC_DATA_W-1:0] out_q;
    logic [`SOC_DATA_W-1:0] in_meta_q;
    logic [`SOC_DATA_W-1:0] in_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q     <= '0;
            in_meta_q <= '0;
            in_q      <= '0;
        end else begin
            in_meta_q <= gpio_in_i;     // two-flop sync
            in_q      <= in_meta_q;
            for (int i = 0; i < `SOC_BE_W; i++) begin
                if (bus.write && (bus.addr == `SOC_GPIO_OUT) && bus.byte_en[i]) begin
                    out_q[8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        if (bus.read && (bus.addr == `SOC_GPIO_OUT)) begin
            bus.rdata = out_q;
        end else if (bus.read && (bus.addr == `SOC_GPIO_IN)) begin
            bus.rdata = in_q;
        end else begin
            bus.rdata = '0;
        end
    end

    assign gpio_out_o = out_q;

endmodule

`default_nettype wire

// ==== logic/soc_bus_pkg.sv ====
/*
  Shared types of the data bus
  dev_sel_e     decoded target device
  sram_state_e  SRAM controller phases
*/
`default_nettype none

package soc_bus_pkg;

    typedef enum logic [1:0] {
        DEV_NONE,
        DEV_SRAM,
        DEV_TICKER,
        DEV_GPIO
    } dev_sel_e;

    typedef enum logic [2:0] {
        SRAM_IDLE,
        SRAM_READ,      // oe_n low, bank word captured at the edge
        SRAM_MERGE,     // write of the merged word
        SRAM_WRITE,     // full-word write
        SRAM_DONE
    } sram_state_e;

endpackage

`default_nettype wire

// ==== logic/soc_bus_top.sv ====
/*
  Data bus subsystem top
  decoder, SRAM controller, tick timer and GPIO,
  with the SRAM strobes split per bank
*/
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_settings.svh"

module soc_bus_top (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire  [`SOC_ADDR_W-1:0]  bus_addr_i,
    input  wire  [`SOC_DATA_W-1:0]  bus_wdata_i,
    input  wire  [`SOC_BE_W-1:0]    bus_byte_en_i,
    input  wire                     bus_read_i,
    input  wire                     bus_write_i,
    output logic [`SOC_DATA_W-1:0]  bus_rdata_o,
    output logic                    bus_stall_o,
    output logic [`SOC_SRAM_AW-1:0] ext_ram_addr_o,
    output logic                    ext_ram_ce_n_o,
    output logic                    ext_ram_oe_n_o,
    output logic                    ext_ram_we_n_o,
    input  wire  [`SOC_DATA_W-1:0]  ext_ram_data_i,
    output logic [`SOC_SRAM_AW-1:0] base_ram_addr_o,
    output logic                    base_ram_ce_n_o,
    output logic                    base_ram_oe_n_o,
    output logic                    base_ram_we_n_o,
    input  wire  [`SOC_DATA_W-1:0]  base_ram_data_i,
    output logic [`SOC_DATA_W-1:0]  ram_data_o,
    output logic                    ram_data_oe_o,
    output logic                    tick_irq_o,
    input  wire  [`SOC_DATA_W-1:0]  gpio_in_i,
    output logic [`SOC_DATA_W-1:0]  gpio_out_o
);

    logic [`SOC_SRAM_AW-1:0] ram_addr;
    logic                    ram_oe_n;
    logic                    ram_we_n;

    dev_bus_if sram_bus ();
    dev_bus_if tick_bus ();
    dev_bus_if gpio_bus ();

    data_bus_decode u_decode (
        .bus_addr_i    (bus_addr_i),
        .bus_wdata_i   (bus_wdata_i),
        .bus_byte_en_i (bus_byte_en_i),
        .bus_read_i    (bus_read_i),
        .bus_write_i   (bus_write_i),
        .bus_rdata_o   (bus_rdata_o),
        .bus_stall_o   (bus_stall_o),
        .sram_bus      (sram_bus),
        .tick_bus      (tick_bus),
        .gpio_bus      (gpio_bus)
    );

    sram_ctrl u_sram (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .bus           (sram_bus),
        .ram_addr_o    (ram_addr),
        .base_ce_n_o   (base_ram_ce_n_o),
        .ext_ce_n_o    (ext_ram_ce_n_o),
        .oe_n_o        (ram_oe_n),
        .we_n_o        (ram_we_n),
        .ram_data_o    (ram_data_o),
        .ram_data_oe_o (ram_data_oe_o),
        .base_data_i   (base_ram_data_i),
        .ext_data_i    (ext_ram_data_i)
    );

    // address and strobes shared, ce_n picks the bank
    assign base_ram_addr_o = ram_addr;
    assign ext_ram_addr_o  = ram_addr;
    assign base_ram_oe_n_o = ram_oe_n;
    assign ext_ram_oe_n_o  = ram_oe_n;
    assign base_ram_we_n_o = ram_we_n;
    assign ext_ram_we_n_o  = ram_we_n;

    ticker_timer u_ticker (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .bus        (tick_bus),
        .tick_irq_o (tick_irq_o)
    );

    gpio_regs u_gpio (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .bus        (gpio_bus),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

endmodule

`default_nettype wire

// ==== logic/sram_ctrl.sv ====
/*
  Two-bank asynchronous SRAM controller
  bank select on the bank bit, access phase machine,
  read word capture and byte merge for partial writes
*/
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_settings.svh"

module sram_ctrl (
    input  wire                     clk,
    input  wire                     arst_n_i,
    dev_bus_if.mem                  bus,
    output logic [`SOC_SRAM_AW-1:0] ram_addr_o,
    output logic                    base_ce_n_o,
    output logic                    ext_ce_n_o,
    output logic                    oe_n_o,
    output logic                    we_n_o,
    output logic [`SOC_DATA_W-1:0]  ram_data_o,
    output logic                    ram_data_oe_o,
    input  wire  [`SOC_DATA_W-1:0]  base_data_i,
    input  wire  [`SOC_DATA_W-1:0]  ext_data_i
);

    soc_bus_pkg::sram_state_e state_q;
    soc_bus_pkg::sram_state_e state_d;
    soc_bus_pkg::sram_state_e phase;
    logic                     full_word;
    logic                     bank_sel;
    logic                     active;
    logic                     writing;
    logic [`SOC_DATA_W-1:0]   rd_word_q;
    logic [`SOC_DATA_W-1:0]   merged;

    assign full_word = &bus.byte_en;
    assign bank_sel  = bus.addr[`SOC_SRAM_BANK_BIT];   // 1 selects ext

    // in idle the new request starts its first phase at once
    always_comb begin
        if (state_q == soc_bus_pkg::SRAM_IDLE) begin
            if (bus.read || (bus.write && !full_word)) begin
                phase = soc_bus_pkg::SRAM_READ;
            end else if (bus.write) begin
                phase = soc_bus_pkg::SRAM_WRITE;
            end else begin
                phase = soc_bus_pkg::SRAM_IDLE;
            end
        end else begin
            phase = state_q;
        end
    end

    always_comb begin
        case (phase)
            soc_bus_pkg::SRAM_READ:  state_d = bus.write ? soc_bus_pkg::SRAM_MERGE
                                                         : soc_bus_pkg::SRAM_DONE;
            soc_bus_pkg::SRAM_WRITE: state_d = soc_bus_pkg::SRAM_DONE;
            soc_bus_pkg::SRAM_MERGE: state_d = soc_bus_pkg::SRAM_DONE;
            default:                 state_d = soc_bus_pkg::SRAM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= soc_bus_pkg::SRAM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == soc_bus_pkg::SRAM_READ) begin
            rd_word_q <= bank_sel ? ext_data_i : base_data_i;
        end
    end

    // enabled bytes from the master, the rest from the word just read
    always_comb begin
        for (int i = 0; i < `SOC_BE_W; i++) begin
            merged[8*i +: 8] = bus.byte_en[i] ? bus.wdata[8*i +: 8] : rd_word_q[8*i +: 8];
        end
    end

    assign writing = (phase == soc_bus_pkg::SRAM_WRITE) || (phase == soc_bus_pkg::SRAM_MERGE);
    assign active  = writing || (phase == soc_bus_pkg::SRAM_READ);

    assign ram_addr_o    = bus.addr[`SOC_SRAM_AW+1:2];  // word address
    assign base_ce_n_o   = !(active && !bank_sel);
    assign ext_ce_n_o    = !(active && bank_sel);
    assign oe_n_o        = !(phase == soc_bus_pkg::SRAM_READ);
    assign we_n_o        = !writing;
    assign ram_data_o    = (phase == soc_bus_pkg::SRAM_MERGE) ? merged : bus.wdata;
    assign ram_data_oe_o = writing;

    assign bus.rdata = rd_word_q;
    assign bus.stall = active;  // low only in done or idle

endmodule

`default_nettype wire

// ==== logic/ticker_timer.sv ====
/*
  Tick timer
  free-running counter, compare register, compare interrupt
*/
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_settings.svh"

module ticker_timer (
    input  wire  clk,
    input  wire  arst_n_i,
    dev_bus_if.regs bus,
    output logic tick_irq_o
);

    logic [`SOC_DATA_W-1:0] count_q;
    logic [`SOC_DATA_W-1:0] compare_q;
    logic                   wr_count;
    logic                   wr_compare;

    assign wr_count   = bus.write && (bus.addr == `SOC_TICK_COUNT);
    assign wr_compare = bus.write && (bus.addr == `SOC_TICK_COMPARE);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q    <= '0;
            compare_q  <= '1;   // far away so no irq straight out of reset
            tick_irq_o <= 1'b0;
        end else begin
            if (wr_count) begin
                count_q <= bus.wdata;
            end else begin
                count_q <= count_q + 1'b1;
            end
            if (wr_compare) begin
                compare_q  <= bus.wdata;
                tick_irq_o <= 1'b0;     // compare write acks the irq
            end else if (count_q == compare_q) begin
                tick_irq_o <= 1'b1;
            end
        end
    end

    always_comb begin
        if (bus.read && (bus.addr == `SOC_TICK_COUNT)) begin
            bus.rdata = count_q;
        end else if (bus.read && (bus.addr == `SOC_TICK_COMPARE)) begin
            bus.rdata = compare_q;
        end else begin
            bus.rdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== sim/sram_model.sv ====
/*
  Behavioral model of one asynchronous 32-bit SRAM bank
  sparse storage, unwritten words read as a fill pattern
*/
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
    parameter logic [11:0] FILL_TAG = 12'h000
) (
    input  wire  [19:0] addr_i,
    input  wire         ce_n_i,
    input  wire         oe_n_i,
    input  wire         we_n_i,
    input  wire         data_oe_i,
    input  wire  [31:0] data_i,
    output logic [31:0] data_o
);

    logic [31:0] mem [int unsigned];

    function automatic logic [31:0] word_at(input logic [19:0] a);
        return mem.exists(a) ? mem[a] : {FILL_TAG, a};   // fill tracks the whole address
    endfunction

    always @(*) begin
        if (!ce_n_i && !oe_n_i) begin
            data_o = word_at(addr_i);
        end else begin
            data_o = '0;
        end
    end

    // strobes and data settle after the edge that opens the write
    always @(negedge we_n_i) begin
        #2;
        if (!ce_n_i && !we_n_i && data_oe_i) begin
            mem[addr_i] = data_i;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_soc_bus_top.sv ====
/*
  Testbench of the data bus subsystem
  directed tests of reset state, SRAM full-word and partial
  accesses, tick timer and GPIO, with a watchdog
*/
`timescale 1ns/1ps
`default_nettype none
`include "soc_bus_settings.svh"

module tb_soc_bus_top;

    localparam int CLK_PERIOD = 8;
    localparam int N_FULL     = 24;
    localparam int N_PART     = 16;
    // ticker, gpio and unmapped accesses plus waits
    localparam int NUM_ACCESSES = 2 * N_FULL + 2 * N_PART + 24;
    localparam logic [11:0] BASE_TAG = 12'hba5;
    localparam logic [11:0] EXT_TAG  = 12'he57;

    logic        clk;
    logic        arst_n;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [3:0]  bus_be;
    logic        bus_read;
    logic        bus_write;
    logic [31:0] gpio_in;
    logic [31:0] bus_rdata;
    logic        bus_stall;
    logic [19:0] ext_addr;
    logic        ext_ce_n;
    logic        ext_oe_n;
    logic        ext_we_n;
    logic [31:0] ext_data;
    logic [19:0] base_addr;
    logic        base_ce_n;
    logic        base_oe_n;
    logic        base_we_n;
    logic [31:0] base_data;
    logic [31:0] ram_data;
    logic        ram_data_oe;
    logic        tick_irq;
    logic [31:0] gpio_out;

    integer      seed = 32'h6f6a_e100;
    int unsigned cycle_cnt = 0;
    logic        base_ce_seen;
    logic        ext_ce_seen;
    logic [31:0] ref_mem [int unsigned];    // keyed by bank and word

    soc_bus_top dut (
        .clk (clk), .arst_n_i (arst_n),
        .bus_addr_i (bus_addr), .bus_wdata_i (bus_wdata), .bus_byte_en_i (bus_be),
        .bus_read_i (bus_read), .bus_write_i (bus_write),
        .bus_rdata_o (bus_rdata), .bus_stall_o (bus_stall),
        .ext_ram_addr_o (ext_addr), .ext_ram_ce_n_o (ext_ce_n), .ext_ram_oe_n_o (ext_oe_n),
        .ext_ram_we_n_o (ext_we_n), .ext_ram_data_i (ext_data),
        .base_ram_addr_o (base_addr), .base_ram_ce_n_o (base_ce_n),
        .base_ram_oe_n_o (base_oe_n), .base_ram_we_n_o (base_we_n),
        .base_ram_data_i (base_data),
        .ram_data_o (ram_data), .ram_data_oe_o (ram_data_oe),
        .tick_irq_o (tick_irq), .gpio_in_i (gpio_in), .gpio_out_o (gpio_out)
    );

    sram_model #(.FILL_TAG(BASE_TAG)) base_bank (
        .addr_i (base_addr), .ce_n_i (base_ce_n), .oe_n_i (base_oe_n), .we_n_i (base_we_n),
        .data_oe_i (ram_data_oe), .data_i (ram_data), .data_o (base_data)
    );

    sram_model #(.FILL_TAG(EXT_TAG)) ext_bank (
        .addr_i (ext_addr), .ce_n_i (ext_ce_n), .oe_n_i (ext_oe_n), .we_n_i (ext_we_n),
        .data_oe_i (ram_data_oe), .data_i (ram_data), .data_o (ext_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        repeat (NUM_ACCESSES * 10) @(posedge clk);
        $display("timeout, bus never completed");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) w[8*i +: 8] = new_w[8*i +: 8];
        end
        return w;
    endfunction

    // expected bank word from the last write or the bank's fill pattern
    function automatic logic [31:0] expect_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[22:2])) return ref_mem[addr[22:2]];
        return {addr[22] ? EXT_TAG : BASE_TAG, addr[21:2]};
    endfunction

    // request held from a falling edge until stall is seen low
    task automatic bus_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] be,
                              output logic [31:0] rdata);
        logic done;
        done = 1'b0;
        base_ce_seen = 1'b0;
        ext_ce_seen = 1'b0;
        @(negedge clk);
        bus_addr = addr;
        bus_wdata = wdata;
        bus_be = be;
        bus_read = !wr;
        bus_write = wr;
        while (!done) begin
            #(CLK_PERIOD / 4);              // middle of the low phase
            done = !bus_stall;
            rdata = bus_rdata;
            base_ce_seen = base_ce_seen | !base_ce_n;
            ext_ce_seen = ext_ce_seen | !ext_ce_n;
            @(negedge clk);
        end
        bus_read = 1'b0;
        bus_write = 1'b0;
    endtask

    task automatic bus_write_word(input logic [31:0] addr, input logic [31:0] data,
                                  input logic [3:0] be);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, be, unused);
    endtask

    task automatic bus_read_word(input logic [31:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, '0, 4'hf, data);
    endtask

    task automatic verify_reset_state();
        logic [31:0] rdata;
        check("base_ram_ce_n_o", base_ce_n, 1);
        check("ext_ram_ce_n_o", ext_ce_n, 1);
        check("base_ram_oe_n_o", base_oe_n, 1);
        check("ext_ram_oe_n_o", ext_oe_n, 1);
        check("base_ram_we_n_o", base_we_n, 1);
        check("ext_ram_we_n_o", ext_we_n, 1);
        check("ram_data_oe_o", ram_data_oe, 0);
        check("bus_stall_o", bus_stall, 0);
        check("tick_irq_o", tick_irq, 0);
        check("gpio_out_o", gpio_out, 0);
        bus_read_word(32'h3000_0010, rdata);
        check("bus_rdata_o unmapped", rdata, 0);
    endtask

    task automatic full_word_traffic();
        logic [31:0] addr_q [$];
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        for (int i = 0; i < N_FULL; i++) begin
            addr = $random(seed) & 32'h007f_fffc;   // bit 22 picks the bank
            data = $random(seed);
            bus_write_word(addr, data, 4'hf);
            check("ext_ram_ce_n_o active on bank bit", ext_ce_seen, addr[22]);
            check("base_ram_ce_n_o active on bank bit", base_ce_seen, !addr[22]);
            ref_mem[addr[22:2]] = data;
            addr_q.push_back(addr);
        end
        foreach (addr_q[i]) begin
            bus_read_word(addr_q[i], rdata);
            check("bus_rdata_o full word", rdata, expect_word(addr_q[i]));
        end
    endtask

    task automatic partial_write_merge();
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  be;
        logic [31:0] rdata;
        for (int i = 0; i < N_PART; i++) begin
            addr = $random(seed) & 32'h007f_fffc;
            data = $random(seed);
            be = $random(seed);
            bus_write_word(addr, data, be);
            ref_mem[addr[22:2]] = merge_bytes(expect_word(addr), data, be);
            bus_read_word(addr, rdata);
            check("bus_rdata_o merged word", rdata, expect_word(addr));
        end
    endtask

    task automatic ticker_count_irq();
        logic [31:0] v;
        logic [31:0] rdata;
        logic [31:0] cmp;
        int unsigned start;
        int unsigned elapsed;
        logic        raised;
        v = $random(seed) & 32'h7fff_ffff;
        bus_write_word(`SOC_TICKER_BASE + `SOC_TICK_COUNT, v, 4'hf);
        start = cycle_cnt;
        repeat (5) @(negedge clk);
        bus_read_word(`SOC_TICKER_BASE + `SOC_TICK_COUNT, rdata);
        elapsed = cycle_cnt - start;
        check("tick count above loaded value", rdata > v, 1);
        check("tick count within elapsed cycles", rdata < v + elapsed + 4, 1);
        cmp = rdata + 20;
        bus_write_word(`SOC_TICKER_BASE + `SOC_TICK_COMPARE, cmp, 4'hf);
        bus_read_word(`SOC_TICKER_BASE + `SOC_TICK_COMPARE, rdata);
        check("tick compare readback", rdata, cmp);
        check("tick_irq_o low before compare match", tick_irq, 0);
        raised = 1'b0;
        for (int i = 0; i < 30 && !raised; i++) begin
            @(negedge clk);
            raised = tick_irq;
        end
        check("tick_irq_o raised within 30 cycles", raised, 1);
        bus_write_word(`SOC_TICKER_BASE + `SOC_TICK_COMPARE, cmp + 1000, 4'hf);
        check("tick_irq_o cleared by compare write", tick_irq, 0);
    endtask

    task automatic gpio_out_in();
        logic [31:0] expected;
        logic [31:0] data;
        logic [3:0]  be;
        logic [31:0] rdata;
        expected = '0;
        for (int i = 0; i < 4; i++) begin
            data = $random(seed);
            be = $random(seed);
            bus_write_word(`SOC_GPIO_BASE + `SOC_GPIO_OUT, data, be);
            expected = merge_bytes(expected, data, be);
            check("gpio_out_o", gpio_out, expected);
            bus_read_word(`SOC_GPIO_BASE + `SOC_GPIO_OUT, rdata);
            check("gpio out readback", rdata, expected);
        end
        data = $random(seed);
        gpio_in = data;             // driven on a falling edge
        repeat (3) @(negedge clk);
        bus_read_word(`SOC_GPIO_BASE + `SOC_GPIO_IN, rdata);
        check("gpio in readback", rdata, data);
    endtask

    initial begin
        arst_n = 1'b0;
        bus_addr = '0;
        bus_wdata = '0;
        bus_be = '0;
        bus_read = 1'b0;
        bus_write = 1'b0;
        gpio_in = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        verify_reset_state();
        full_word_traffic();
        partial_write_merge();
        ticker_count_irq();
        gpio_out_in();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_bus_top.f ====
+incdir+include
logic/soc_bus_pkg.sv
logic/dev_bus_if.sv
logic/data_bus_decode.sv
logic/sram_ctrl.sv
logic/ticker_timer.sv
logic/gpio_regs.sv
logic/soc_bus_top.sv
sim/sram_model.sv
sim/tb_soc_bus_top.sv
